// ==== common/exec_pkg.sv ====
package exec_pkg;

  localparam int xlen = 32;
  localparam int log2_xlen = $clog2(xlen);
  localparam int reg_addr_w = 5;

  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_sll  = 4'd2,
    alu_slt  = 4'd3,
    alu_sltu = 4'd4,
    alu_xor  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_or   = 4'd8,
    alu_and  = 4'd9
  } alu_op_t;

  // same order as funct3 of the M extension.
  typedef enum logic [2:0] {
    md_mul    = 3'd0,
    md_mulh   = 3'd1,
    md_mulhsu = 3'd2,
    md_mulhu  = 3'd3,
    md_div    = 3'd4,
    md_divu   = 3'd5,
    md_rem    = 3'd6,
    md_remu   = 3'd7
  } muldiv_op_t;

  typedef struct packed {
    logic                  valid;
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       rdata1;
    logic [xlen-1:0]       rdata2;
    logic [xlen-1:0]       imm;
    logic                  use_imm;     // imm replaces rdata2 at the alu.
    alu_op_t               alu_op;
    logic                  muldiv;
    muldiv_op_t            muldiv_op;
    logic                  lui;
    logic                  auipc;
    logic                  jal;         // jal and jalr.
    logic                  wren;
    logic [reg_addr_w-1:0] waddr;
  } exe_req_t;

  typedef struct packed {
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    alu_op_t         alu_op;
  } alu_in_t;

  typedef struct packed {
    logic            enable;
    logic [xlen-1:0] rdata1;
    logic [xlen-1:0] rdata2;
    muldiv_op_t      muldiv_op;
  } muldiv_in_t;

  typedef struct packed {
    logic            ready;
    logic [xlen-1:0] result;
  } muldiv_out_t;

  typedef struct packed {
    logic                  wren;
    logic [reg_addr_w-1:0] waddr;
    logic [xlen-1:0]       wdata;
  } reg_wr_t;

  typedef struct packed {
    exe_req_t req;
    logic     started;  // enable pulse already sent.
  } execute_reg_t;

  localparam exe_req_t init_exe_req = '{
    valid: 1'b0, pc: '0, rdata1: '0, rdata2: '0, imm: '0, use_imm: 1'b0,
    alu_op: alu_add, muldiv: 1'b0, muldiv_op: md_mul, lui: 1'b0,
    auipc: 1'b0, jal: 1'b0, wren: 1'b0, waddr: '0
  };

  localparam execute_reg_t init_execute_reg = '{req: init_exe_req, started: 1'b0};

endpackage

// ==== logic/int_alu.sv ====
`timescale 1ns/1ps

module int_alu (
  input  exec_pkg::alu_in_t         in,
  output logic [exec_pkg::xlen-1:0] res
);
  import exec_pkg::*;

  logic [log2_xlen-1:0] shamt;

  always_comb begin
    shamt = in.b[log2_xlen-1:0];  // rv32 uses only the low 5 bits.

    case (in.alu_op)
      alu_add: begin
        res = in.a + in.b;
      end
      alu_sub: begin
        res = in.a - in.b;
      end
      alu_sll: begin
        res = in.a << shamt;
      end
      alu_slt: begin
        res = {{(xlen-1){1'b0}}, $signed(in.a) < $signed(in.b)};
      end
      alu_sltu: begin
        res = {{(xlen-1){1'b0}}, in.a < in.b};
      end
      alu_xor: begin
        res = in.a ^ in.b;
      end
      alu_srl: begin
        res = in.a >> shamt;
      end
      alu_sra: begin
        // sign bit fills from the left.
        res = $unsigned($signed(in.a) >>> shamt);
      end
      alu_or: begin
        res = in.a | in.b;
      end
      alu_and: begin
        res = in.a & in.b;
      end
      default: begin
        res = '0;
        assert (!$isunknown(in.alu_op))
          else $error("int_alu: unknown alu_op %b", in.alu_op);
      end
    endcase
  end

endmodule

// ==== muldiv/muldiv_unit.sv ====
`timescale 1ns/1ps

module muldiv_unit (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  abort,
  input  exec_pkg::muldiv_in_t  in,
  output exec_pkg::muldiv_out_t out
);
  import exec_pkg::*;

  logic                 busy;
  logic [log2_xlen-1:0] count;
  muldiv_op_t           op;
  logic                 neg_res;
  logic [xlen-1:0]      b_mag;
  logic [2*xlen-1:0]    acc;    // product, or {remainder, quotient}.

  logic                 a_signed;
  logic                 b_signed;
  logic                 a_neg;
  logic                 b_neg;
  logic                 b_zero;
  logic                 neg_in;
  logic [xlen-1:0]      a_in_mag;
  logic [xlen-1:0]      b_in_mag;

  logic [xlen:0]        mul_sum;
  logic [xlen:0]        rem_shift;
  logic [xlen:0]        trial;
  logic [2*xlen-1:0]    acc_next;
  logic [2*xlen-1:0]    prod_fixed;
  logic [xlen-1:0]      quot_fixed;
  logic [xlen-1:0]      rem_fixed;

  // operand magnitudes and result sign, taken at enable.
  always_comb begin
    a_signed = in.muldiv_op inside {md_mul, md_mulh, md_mulhsu, md_div, md_rem};
    b_signed = in.muldiv_op inside {md_mul, md_mulh, md_div, md_rem};
    a_neg = a_signed & in.rdata1[xlen-1];
    b_neg = b_signed & in.rdata2[xlen-1];
    b_zero = (in.rdata2 == '0);
    a_in_mag = a_neg ? -in.rdata1 : in.rdata1;
    b_in_mag = b_neg ? -in.rdata2 : in.rdata2;

    case (in.muldiv_op)
      md_div, md_divu: neg_in = (a_neg ^ b_neg) & ~b_zero;  // x/0 stays all ones.
      md_rem, md_remu: neg_in = a_neg;                      // remainder follows dividend.
      default:         neg_in = a_neg ^ b_neg;
    endcase
  end

  // one shift-and-add or restoring-division step.
  always_comb begin
    mul_sum = {1'b0, acc[2*xlen-1:xlen]} + (acc[0] ? {1'b0, b_mag} : '0);
    rem_shift = acc[2*xlen-1:xlen-1];
    trial = rem_shift - {1'b0, b_mag};

    if (op inside {md_div, md_divu, md_rem, md_remu}) begin
      if (trial[xlen] == 1'b0) begin
        acc_next = {trial[xlen-1:0], acc[xlen-2:0], 1'b1};
      end else begin
        acc_next = {rem_shift[xlen-1:0], acc[xlen-2:0], 1'b0};
      end
    end else begin
      acc_next = {mul_sum, acc[xlen-1:1]};
    end
  end

  // result comes straight off the last step.
  always_comb begin
    prod_fixed = neg_res ? -acc_next : acc_next;
    quot_fixed = neg_res ? -acc_next[xlen-1:0] : acc_next[xlen-1:0];
    rem_fixed = neg_res ? -acc_next[2*xlen-1:xlen] : acc_next[2*xlen-1:xlen];

    case (op)
      md_mul:          out.result = prod_fixed[xlen-1:0];
      md_div, md_divu: out.result = quot_fixed;
      md_rem, md_remu: out.result = rem_fixed;
      default:         out.result = prod_fixed[2*xlen-1:xlen];
    endcase

    out.ready = busy & (count == '1) & ~abort;
  end

  always_ff @(posedge clk) begin
    if (rst == 1'b0) begin
      busy <= 1'b0;
      count <= '0;
    end else if (abort == 1'b1) begin
      busy <= 1'b0;
      count <= '0;
    end else if (in.enable == 1'b1) begin
      busy <= 1'b1;
      count <= '0;
    end else if (busy == 1'b1) begin
      count <= count + 1'b1;   // wraps to zero after the last step.
      if (count == '1) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in.enable == 1'b1) begin
      op <= in.muldiv_op;
      neg_res <= neg_in;
      b_mag <= b_in_mag;
      acc <= {{xlen{1'b0}}, a_in_mag};
    end else if (busy == 1'b1) begin
      acc <= acc_next;
    end
  end

  a_enable_idle: assert property (@(posedge clk) disable iff (rst == 1'b0)
    in.enable |-> !busy);

  a_ready_pulse: assert property (@(posedge clk) disable iff (rst == 1'b0)
    out.ready |=> !out.ready);

endmodule

// ==== logic/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
  input  logic                     clk,
  input  logic                     rst,
  input  exec_pkg::exe_req_t       req,
  input  logic                     clear,
  output exec_pkg::alu_in_t        alu_in,
  input  logic [exec_pkg::xlen-1:0] alu_res,
  output exec_pkg::muldiv_in_t     muldiv_in,
  input  exec_pkg::muldiv_out_t    muldiv_out,
  output exec_pkg::reg_wr_t        wr,
  output logic                     stall
);
  import exec_pkg::*;

  execute_reg_t r;
  execute_reg_t rin;
  execute_reg_t v;

  always_comb begin

    v = r;

    alu_in.a = r.req.rdata1;
    alu_in.b = r.req.use_imm ? r.req.imm : r.req.rdata2;
    alu_in.alu_op = r.req.alu_op;

    // a single pulse in the first cycle of a muldiv instruction.
    muldiv_in.enable = r.req.valid & r.req.muldiv & ~r.started & ~clear;
    muldiv_in.rdata1 = r.req.rdata1;
    muldiv_in.rdata2 = r.req.rdata2;
    muldiv_in.muldiv_op = r.req.muldiv_op;

    stall = r.req.valid & r.req.muldiv & ~muldiv_out.ready;

    wr.waddr = r.req.waddr;
    if (r.req.auipc == 1'b1) begin
      wr.wdata = r.req.pc + r.req.imm;
    end else if (r.req.lui == 1'b1) begin
      wr.wdata = r.req.imm;
    end else if (r.req.jal == 1'b1) begin
      wr.wdata = r.req.pc + xlen'(4);  // link address.
    end else if (r.req.muldiv == 1'b1) begin
      wr.wdata = muldiv_out.result;
    end else begin
      wr.wdata = alu_res;
    end

    wr.wren = r.req.valid & r.req.wren & (|r.req.waddr) & ~stall & ~clear;

    if (muldiv_in.enable == 1'b1) begin
      v.started = 1'b1;
    end

    // register holds while stalled.
    if (stall == 1'b0) begin
      v.req = req;
      v.started = 1'b0;
    end

    // clear wins over a new request.
    if (clear == 1'b1) begin
      v = init_execute_reg;
    end

    rin = v;

  end

  always_ff @(posedge clk) begin
    if (rst == 1'b0) begin
      r <= init_execute_reg;
    end else begin
      r <= rin;
    end
  end

  a_no_write_in_stall: assert property (@(posedge clk) disable iff (rst == 1'b0)
    !(wr.wren && stall));

endmodule

// ==== logic/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
  input  logic               clk,
  input  logic               rst,
  input  exec_pkg::exe_req_t req,
  input  logic               clear,
  output exec_pkg::reg_wr_t  wr,
  output logic               stall
);
  import exec_pkg::*;

  alu_in_t         alu_in;
  logic [xlen-1:0] alu_res;
  muldiv_in_t      muldiv_in;
  muldiv_out_t     muldiv_out;

  execute_stage u_stage (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .clear      (clear),
    .alu_in     (alu_in),
    .alu_res    (alu_res),
    .muldiv_in  (muldiv_in),
    .muldiv_out (muldiv_out),
    .wr         (wr),
    .stall      (stall)
  );

  int_alu u_alu (
    .in  (alu_in),
    .res (alu_res)
  );

  // a clear also drops any running muldiv operation.
  muldiv_unit u_muldiv (
    .clk   (clk),
    .rst   (rst),
    .abort (clear),
    .in    (muldiv_in),
    .out   (muldiv_out)
  );

endmodule

// ==== test/execute_tb.sv ====
`timescale 1ns/1ps

module execute_tb;
  import exec_pkg::*;

  localparam int n_alu = 300;
  localparam int n_upper = 45;
  localparam int n_muldiv = 200;
  localparam int n_clear = 6;
  localparam int n_requests = n_alu + n_upper + n_muldiv + 2 * n_clear;
  localparam int muldiv_latency = 33;
  localparam int timeout_ns = (n_requests * 40 + 50) * 100;

  logic        clk;
  logic        rst;
  exe_req_t    req;
  logic        clear;
  reg_wr_t     wr;
  logic        stall;
  logic [31:0] rng_state = 32'd47407;
  exe_req_t    pending[$];  // accepted requests awaiting their result.
  int          age;

  execute_unit dut (
    .clk   (clk),
    .rst   (rst),
    .req   (req),
    .clear (clear),
    .wr    (wr),
    .stall (stall)
  );

  function automatic logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic logic [31:0] alu_value(input exe_req_t r);
    logic [31:0] b;
    int          sa;
    b = r.use_imm ? r.imm : r.rdata2;
    sa = r.rdata1;
    case (r.alu_op)
      alu_add:  return r.rdata1 + b;
      alu_sub:  return r.rdata1 - b;
      alu_sll:  return r.rdata1 << b[4:0];
      alu_slt:  return (sa < int'(b)) ? 32'd1 : 32'd0;
      alu_sltu: return (r.rdata1 < b) ? 32'd1 : 32'd0;
      alu_xor:  return r.rdata1 ^ b;
      alu_srl:  return r.rdata1 >> b[4:0];
      alu_sra:  return sa >>> b[4:0];
      alu_or:   return r.rdata1 | b;
      default:  return r.rdata1 & b;
    endcase
  endfunction

  function automatic logic [31:0] muldiv_value(input exe_req_t r);
    int          a_i;
    int          b_i;
    longint      a_s;
    longint      b_s;
    longint      a_u;
    longint      b_u;
    logic [63:0] p;
    a_i = r.rdata1;
    b_i = r.rdata2;
    a_s = a_i;  // sign extended.
    b_s = b_i;
    a_u = {32'd0, r.rdata1};
    b_u = {32'd0, r.rdata2};
    case (r.muldiv_op)
      md_mulhsu: p = a_s * b_u;
      md_mulhu:  p = a_u * b_u;
      default:   p = a_s * b_s;
    endcase
    case (r.muldiv_op)
      md_mul:  return p[31:0];
      md_div: begin
        if (b_i == 0) return '1;
        if (r.rdata1 == 32'h8000_0000 && b_i == -1) return r.rdata1;  // overflow.
        return a_i / b_i;
      end
      md_divu: return (b_i == 0) ? '1 : r.rdata1 / r.rdata2;
      md_rem: begin
        if (b_i == 0) return r.rdata1;
        if (r.rdata1 == 32'h8000_0000 && b_i == -1) return '0;
        return a_i % b_i;
      end
      md_remu: return (b_i == 0) ? r.rdata1 : r.rdata1 % r.rdata2;
      default: return p[63:32];
    endcase
  endfunction

  function automatic reg_wr_t ref_result(input exe_req_t r);
    reg_wr_t w;
    w.wren = r.valid && r.wren && (r.waddr != '0);
    w.waddr = r.waddr;
    if (r.auipc) begin
      w.wdata = r.pc + r.imm;
    end else if (r.lui) begin
      w.wdata = r.imm;
    end else if (r.jal) begin
      w.wdata = r.pc + 32'd4;
    end else if (r.muldiv) begin
      w.wdata = muldiv_value(r);
    end else begin
      w.wdata = alu_value(r);
    end
    return w;
  endfunction

  function automatic exe_req_t random_req(input logic is_muldiv);
    exe_req_t    r;
    logic [31:0] pick;
    pick = next_random();
    r = init_exe_req;
    r.valid = 1'b1;
    r.pc = next_random() & ~32'd3;
    r.rdata1 = next_random();
    r.rdata2 = next_random();
    r.imm = next_random();
    if (pick[0]) r.imm = {{20{r.imm[11]}}, r.imm[11:0]};  // i-type range.
    r.use_imm = pick[1];
    r.alu_op = alu_op_t'(4'(pick[7:4] % 10));
    r.muldiv = is_muldiv;
    r.muldiv_op = muldiv_op_t'(pick[10:8]);
    r.wren = pick[15:12] != 4'd0;
    r.waddr = pick[20:16];
    if (is_muldiv && pick[23:21] == 3'd0) r.rdata2 = '0;
    if (is_muldiv && pick[23:21] == 3'd1) begin
      r.rdata1 = 32'h8000_0000;
      r.rdata2 = '1;
    end
    return r;
  endfunction

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_wr(input reg_wr_t act, input reg_wr_t exp);
    if (act.wren !== exp.wren ||
        (exp.wren && (act.waddr !== exp.waddr || act.wdata !== exp.wdata))) begin
      $display(
        "MISMATCH at %0t: wr got wren=%b waddr=%0d wdata=%h, expected wren=%b waddr=%0d wdata=%h",
        $time, act.wren, act.waddr, act.wdata, exp.wren, exp.waddr, exp.wdata);
      abort_run();
    end
  endtask

  task automatic check_stall(input logic act, input logic exp);
    if (act !== exp) begin
      $display("MISMATCH at %0t: stall got %b expected %b", $time, act, exp);
      abort_run();
    end
  endtask

  // holds req until the stage takes it, then leaves the bus idle.
  task automatic send(input exe_req_t r);
    req = r;
    do @(negedge clk); while (stall);
    @(posedge clk);
    #10;
    req = init_exe_req;
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // compare process samples mid-cycle.
  initial begin
    exe_req_t head;
    logic     exp_stall;
    reg_wr_t  no_write;
    no_write = '0;
    age = 0;
    forever begin
      @(negedge clk);
      if (rst == 1'b1) begin
        if (pending.size() != 0) begin
          head = pending[0];
          age++;
          exp_stall = head.muldiv && age < muldiv_latency;
          check_stall(stall, exp_stall);
          if (clear == 1'b1) begin
            check_wr(wr, no_write);  // flushed instruction never writes.
            head = pending.pop_front();
          end else if (!exp_stall) begin
            head = pending.pop_front();
            check_wr(wr, ref_result(head));
          end else begin
            check_wr(wr, no_write);
          end
        end else begin
          check_stall(stall, 1'b0);
          check_wr(wr, no_write);
        end
        if (req.valid && !stall && !clear) begin
          pending.push_back(req);
          age = 0;
        end
      end
    end
  end

  initial begin
    #(timeout_ns);
    $display("timeout after %0d ns with %0d requests outstanding", timeout_ns, pending.size());
    abort_run();
  end

  initial begin
    exe_req_t r;
    rst = 1'b0;
    clear = 1'b0;
    req = init_exe_req;
    repeat (4) @(posedge clk);
    #10;
    rst = 1'b1;
    @(negedge clk);
    check_stall(stall, 1'b0);
    check_wr(wr, reg_wr_t'('0));
    @(posedge clk);
    #10;
    for (int i = 0; i < n_alu; i++) send(random_req(1'b0));
    for (int i = 0; i < n_upper; i++) begin
      r = random_req(1'b0);
      case (i % 3)
        0:       r.lui = 1'b1;
        1:       r.auipc = 1'b1;
        default: r.jal = 1'b1;
      endcase
      if (i % 3 != 2) r.imm[11:0] = '0;
      if (i % 5 == 4) r.waddr = '0;
      if (i % 7 == 6) r.wren = 1'b0;
      send(r);
    end
    for (int i = 0; i < n_muldiv; i++) send(random_req(1'b1));
    for (int i = 0; i < n_clear; i++) begin
      send(random_req(1'b1));
      repeat (1 + next_random() % 25) @(posedge clk);
      #10;
      clear = 1'b1;
      @(posedge clk);
      #10;
      clear = 1'b0;
      send(random_req(i[0]));
    end
    while (pending.size() != 0) @(posedge clk);
    repeat (3) @(posedge clk);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// ==== sources.f ====
common/exec_pkg.sv
logic/int_alu.sv
muldiv/muldiv_unit.sv
logic/execute_stage.sv
logic/execute_unit.sv
test/execute_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the execute stage testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f sources.f --top-module execute_tb -o execute_tb_sim
if [ $? -ne 0 ]; then
  echo "run.sh: verilator build failed"
  exit 1
fi

./obj_dir/execute_tb_sim > "$log" 2>&1
status=$?
cat "$log"

if grep -q "SIMULATION FAILED" "$log"; then
  echo "run.sh: test failed, see $log"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "run.sh: simulator exited with status $status"
  exit 1
fi

echo "run.sh: test passed"
exit 0
